//--- axi_fifo_bridge_pkg.sv
package axi_fifo_bridge_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    // AXI data bus and FIFO word
    localparam int data_w  = 128;
    // Byte address, 64-byte window
    localparam int addr_w  = 6;
    localparam int id_w    = 16;
    // AxLEN field
    localparam int len_w   = 8;
    // Inbound FIFO fill count
    localparam int level_w = 10;
    localparam int resp_w  = 2;

    //////////////////////////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////////////////////////

    // FIFO data, write pushes outbound, read pops inbound
    localparam logic [addr_w-1:0] addr_fifo = 6'h00;
    // Flush control on writes, fill level on reads
    localparam logic [addr_w-1:0] addr_ctrl = 6'h10;

    // Response codes
    localparam logic [resp_w-1:0] resp_okay   = 2'b00;
    localparam logic [resp_w-1:0] resp_slverr = 2'b10;

    //////////////////////////////////////////////////////////////////////
    // FSM encodings
    //////////////////////////////////////////////////////////////////////

    // Write side
    localparam int wr_state_w = 3;
    localparam logic [wr_state_w-1:0] wr_idle = 3'd0;
    localparam logic [wr_state_w-1:0] wr_data = 3'd1;
    localparam logic [wr_state_w-1:0] wr_ctrl = 3'd2;
    localparam logic [wr_state_w-1:0] wr_disc = 3'd3;
    localparam logic [wr_state_w-1:0] wr_resp = 3'd4;

    // Read side
    localparam int rd_state_w = 2;
    localparam logic [rd_state_w-1:0] rd_idle  = 2'd0;
    localparam logic [rd_state_w-1:0] rd_burst = 2'd1;
    localparam logic [rd_state_w-1:0] rd_wait  = 2'd2;

    //////////////////////////////////////////////////////////////////////
    // Channel types
    //////////////////////////////////////////////////////////////////////

    // AW or AR request
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [id_w-1:0]   id;
        logic [len_w-1:0]  len;
    } axi_addr_req_t;

    // B response, or response part of R
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [resp_w-1:0] resp;
    } axi_resp_t;

    // Control word at addr_ctrl
    typedef struct packed {
        logic [data_w-3:0] rsvd;
        // Inbound core flush request
        logic              rti_flush;
        // Outbound core flush request
        logic              rto_flush;
    } flush_cmd_t;

    // One W beat, seen as data or as flush command
    typedef union packed {
        logic [data_w-1:0] raw;
        flush_cmd_t        flush;
    } axi_word_u;

endpackage

//--- axi_write_ctrl.sv
module axi_write_ctrl
    import axi_fifo_bridge_pkg::*;
(
    input  logic              s_axi_aclk,
    input  logic              s_axi_aresetn,

    // AW channel
    input  axi_addr_req_t     aw_req,
    input  logic              aw_valid,
    output logic              aw_ready,

    // W channel
    input  axi_word_u         w_data,
    input  logic              w_valid,
    input  logic              w_last,
    output logic              w_ready,

    // B channel
    output axi_resp_t         b_resp,
    output logic              b_valid,
    input  logic              b_ready,

    // Outbound core
    output logic              rto_core_write,
    output logic [data_w-1:0] rto_core_fifo_din,
    input  logic              rto_core_full,
    output logic              rto_core_flush,
    output logic              rto_core_reset,

    // Inbound core flush
    output logic              rti_core_flush
);

    logic [wr_state_w-1:0] state;
    logic [wr_state_w-1:0] aw_target;
    logic                  aw_fire;
    logic                  w_fire;
    logic                  in_data;
    logic                  in_ctrl;

    //////////////////////////////////////////////////////////////////////
    // Handshakes
    //////////////////////////////////////////////////////////////////////

    assign in_data = (state == wr_data);
    assign in_ctrl = (state == wr_ctrl);

    // New request only from idle
    assign aw_ready = (state == wr_idle);
    // Data beats stall on full, control and discard never stall
    assign w_ready  = (in_data && !rto_core_full) || in_ctrl || (state == wr_disc);
    // Response state holds B until taken
    assign b_valid  = (state == wr_resp);

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;

    // Address decode into burst type
    always_comb begin
        case (aw_req.addr)
            addr_fifo: aw_target = wr_data;
            addr_ctrl: aw_target = wr_ctrl;
            default:   aw_target = wr_disc;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Write FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state <= wr_idle;
        end else begin
            case (state)
                wr_idle: begin
                    if (aw_fire) begin
                        state <= aw_target;
                    end
                end
                // Burst end follows WLAST only
                wr_data, wr_ctrl, wr_disc: begin
                    if (w_fire && w_last) begin
                        state <= wr_resp;
                    end
                end
                wr_resp: begin
                    if (b_ready) begin
                        state <= wr_idle;
                    end
                end
                default: begin
                    state <= wr_idle;
                end
            endcase
        end
    end

    // ID echo and status, fixed at AW time
    always_ff @(posedge s_axi_aclk) begin
        if (aw_fire) begin
            b_resp.id   <= aw_req.id;
            b_resp.resp <= (aw_target == wr_disc) ? resp_slverr : resp_okay;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Core strobes
    //////////////////////////////////////////////////////////////////////

    // One cycle after each accepted beat
    // Outbound core full is expected to leave one word of headroom
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            rto_core_write <= 1'b0;
            rto_core_flush <= 1'b0;
            rti_core_flush <= 1'b0;
        end else begin
            rto_core_write <= w_fire && in_data;
            // Control beat decoded through flush view
            rto_core_flush <= w_fire && in_ctrl && w_data.flush.rto_flush;
            rti_core_flush <= w_fire && in_ctrl && w_data.flush.rti_flush;
        end
    end

    // Data word, qualified by rto_core_write
    always_ff @(posedge s_axi_aclk) begin
        if (w_fire && in_data) begin
            rto_core_fifo_din <= w_data.raw;
        end
    end

    // Outbound core reset, released one clock after the bus
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            rto_core_reset <= 1'b1;
        end else begin
            rto_core_reset <= 1'b0;
        end
    end

endmodule

//--- axi_read_ctrl.sv
module axi_read_ctrl
    import axi_fifo_bridge_pkg::*;
(
    input  logic               s_axi_aclk,
    input  logic               s_axi_aresetn,

    // AR channel
    input  axi_addr_req_t      ar_req,
    input  logic               ar_valid,
    output logic               ar_ready,

    // R channel
    output logic [data_w-1:0]  r_data,
    output axi_resp_t          r_resp,
    output logic               r_valid,
    output logic               r_last,
    input  logic               r_ready,

    // Inbound core, first-word-fall-through
    input  logic [data_w-1:0]  rti_core_fifo_dout,
    input  logic               rti_core_empty,
    input  logic [level_w-1:0] data_num,
    output logic               rti_core_rd_en,
    output logic               rti_core_reset
);

    logic [rd_state_w-1:0] state;
    logic [len_w-1:0]      beats_left;
    logic                  ar_fire;
    logic                  ar_burst;
    logic                  r_take;
    logic                  load;
    logic                  last_pop;

    //////////////////////////////////////////////////////////////////////
    // Handshakes and pop rule
    //////////////////////////////////////////////////////////////////////

    assign ar_ready = (state == rd_idle);
    assign ar_fire  = ar_valid && ar_ready;
    assign r_take   = r_valid && r_ready;

    // FIFO burst only if a word is there at AR time
    assign ar_burst = (ar_req.addr == addr_fifo) && !rti_core_empty;

    // R register free or draining this cycle, and a word to pop
    assign load     = (state == rd_burst) && (!r_valid || r_ready) && !rti_core_empty;
    assign last_pop = (beats_left == '0);

    // Pop in the same cycle the word is captured
    assign rti_core_rd_en = load;

    //////////////////////////////////////////////////////////////////////
    // Read FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state   <= rd_idle;
            r_valid <= 1'b0;
        end else begin
            case (state)
                rd_idle: begin
                    if (ar_fire) begin
                        if (ar_burst) begin
                            state <= rd_burst;
                        end else begin
                            // Level or error, single beat right away
                            state   <= rd_wait;
                            r_valid <= 1'b1;
                        end
                    end
                end
                rd_burst: begin
                    if (load) begin
                        r_valid <= 1'b1;
                        if (last_pop) begin
                            state <= rd_wait;
                        end
                    end else if (r_take) begin
                        r_valid <= 1'b0;
                    end
                end
                // Final beat held until taken
                rd_wait: begin
                    if (r_take) begin
                        r_valid <= 1'b0;
                        state   <= rd_idle;
                    end
                end
                default: begin
                    state <= rd_idle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // R beat payload
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (ar_fire) begin
            r_resp.id  <= ar_req.id;
            // Pops still owed after the first
            beats_left <= ar_req.len;
            if (ar_burst) begin
                r_resp.resp <= resp_okay;
            end else if (ar_req.addr == addr_ctrl) begin
                r_resp.resp <= resp_okay;
                r_data      <= {{(data_w - level_w){1'b0}}, data_num};
                r_last      <= 1'b1;
            end else begin
                // Empty FIFO or unmapped address
                r_resp.resp <= resp_slverr;
                r_data      <= '0;
                r_last      <= 1'b1;
            end
        end else if (load) begin
            r_data     <= rti_core_fifo_dout;
            r_last     <= last_pop;
            beats_left <= beats_left - 1'b1;
        end
    end

    // Inbound core reset, released one clock after the bus
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            rti_core_reset <= 1'b1;
        end else begin
            rti_core_reset <= 1'b0;
        end
    end

endmodule

//--- axi_fifo_bridge.sv
module axi_fifo_bridge
    import axi_fifo_bridge_pkg::*;
(
    input  logic               s_axi_aclk,
    input  logic               s_axi_aresetn,

    // AXI4 write address
    input  logic [addr_w-1:0]  s_axi_awaddr,
    input  logic [id_w-1:0]    s_axi_awid,
    input  logic [len_w-1:0]   s_axi_awlen,
    input  logic               s_axi_awvalid,
    output logic               s_axi_awready,

    // AXI4 write data
    input  logic [data_w-1:0]  s_axi_wdata,
    input  logic               s_axi_wvalid,
    input  logic               s_axi_wlast,
    output logic               s_axi_wready,

    // AXI4 write response
    output logic [id_w-1:0]    s_axi_bid,
    output logic [resp_w-1:0]  s_axi_bresp,
    output logic               s_axi_bvalid,
    input  logic               s_axi_bready,

    // AXI4 read address
    input  logic [addr_w-1:0]  s_axi_araddr,
    input  logic [id_w-1:0]    s_axi_arid,
    input  logic [len_w-1:0]   s_axi_arlen,
    input  logic               s_axi_arvalid,
    output logic               s_axi_arready,

    // AXI4 read data
    output logic [id_w-1:0]    s_axi_rid,
    output logic [data_w-1:0]  s_axi_rdata,
    output logic [resp_w-1:0]  s_axi_rresp,
    output logic               s_axi_rlast,
    output logic               s_axi_rvalid,
    input  logic               s_axi_rready,

    // Outbound core
    output logic               rto_core_reset,
    output logic               rto_core_flush,
    output logic               rto_core_write,
    output logic [data_w-1:0]  rto_core_fifo_din,
    input  logic               rto_core_full,

    // Inbound core
    output logic               rti_core_reset,
    output logic               rti_core_flush,
    output logic               rti_core_rd_en,
    input  logic [data_w-1:0]  rti_core_fifo_dout,
    input  logic               rti_core_empty,
    input  logic [level_w-1:0] data_num
);

    axi_addr_req_t aw_req;
    axi_addr_req_t ar_req;
    axi_word_u     w_word;
    axi_resp_t     b_resp;
    axi_resp_t     r_resp;

    // Request packing
    assign aw_req = '{addr: s_axi_awaddr, id: s_axi_awid, len: s_axi_awlen};
    assign ar_req = '{addr: s_axi_araddr, id: s_axi_arid, len: s_axi_arlen};
    // W beat as union, view picked by the write side
    assign w_word = axi_word_u'(s_axi_wdata);

    // Response unpacking
    assign s_axi_bid   = b_resp.id;
    assign s_axi_bresp = b_resp.resp;
    assign s_axi_rid   = r_resp.id;
    assign s_axi_rresp = r_resp.resp;

    //////////////////////////////////////////////////////////////////////
    // Write side, outbound core
    //////////////////////////////////////////////////////////////////////

    axi_write_ctrl u_write_ctrl (
        .s_axi_aclk        (s_axi_aclk),
        .s_axi_aresetn     (s_axi_aresetn),
        .aw_req            (aw_req),
        .aw_valid          (s_axi_awvalid),
        .aw_ready          (s_axi_awready),
        .w_data            (w_word),
        .w_valid           (s_axi_wvalid),
        .w_last            (s_axi_wlast),
        .w_ready           (s_axi_wready),
        .b_resp            (b_resp),
        .b_valid           (s_axi_bvalid),
        .b_ready           (s_axi_bready),
        .rto_core_write    (rto_core_write),
        .rto_core_fifo_din (rto_core_fifo_din),
        .rto_core_full     (rto_core_full),
        .rto_core_flush    (rto_core_flush),
        .rto_core_reset    (rto_core_reset),
        .rti_core_flush    (rti_core_flush)
    );

    //////////////////////////////////////////////////////////////////////
    // Read side, inbound core
    //////////////////////////////////////////////////////////////////////

    axi_read_ctrl u_read_ctrl (
        .s_axi_aclk         (s_axi_aclk),
        .s_axi_aresetn      (s_axi_aresetn),
        .ar_req             (ar_req),
        .ar_valid           (s_axi_arvalid),
        .ar_ready           (s_axi_arready),
        .r_data             (s_axi_rdata),
        .r_resp             (r_resp),
        .r_valid            (s_axi_rvalid),
        .r_last             (s_axi_rlast),
        .r_ready            (s_axi_rready),
        .rti_core_fifo_dout (rti_core_fifo_dout),
        .rti_core_empty     (rti_core_empty),
        .data_num           (data_num),
        .rti_core_rd_en     (rti_core_rd_en),
        .rti_core_reset     (rti_core_reset)
    );

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // Period of 8 time units
    localparam int half_period  = 4;
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Release just after a rising edge, like the rest of the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

//--- axi_fifo_bridge_asserts.sv
module axi_fifo_bridge_asserts (
    input logic s_axi_aclk,
    input logic s_axi_aresetn,
    input logic s_axi_bvalid,
    input logic s_axi_bready,
    input logic s_axi_rvalid,
    input logic s_axi_rready,
    input logic rto_core_write,
    input logic rto_core_full,
    input logic rti_core_rd_en,
    input logic rti_core_empty,
    input logic rto_core_flush,
    input logic rti_core_flush
);

    // Failed assertion count, read by the testbench at the end
    int fail_cnt = 0;

    //////////////////////////////////////////////////////////////////////
    // Handshake rules
    //////////////////////////////////////////////////////////////////////

    // B held until taken
    bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
    else begin
        fail_cnt++;
        $error("bvalid dropped before bready");
    end

    // R beat held until taken
    rvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid)
    else begin
        fail_cnt++;
        $error("rvalid dropped before rready");
    end

    //////////////////////////////////////////////////////////////////////
    // Core strobes
    //////////////////////////////////////////////////////////////////////

    no_write_full: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        !(rto_core_write && rto_core_full))
    else begin
        fail_cnt++;
        $error("outbound write while full");
    end

    // Pop only from a non-empty core, popped word shows up as an R beat
    no_pop_empty: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        rti_core_rd_en |-> !rti_core_empty ##1 s_axi_rvalid)
    else begin
        fail_cnt++;
        $error("inbound pop while empty or popped word not presented on R");
    end

    // Flush strobes are single cycle
    rto_flush_pulse: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        rto_core_flush |=> !rto_core_flush)
    else begin
        fail_cnt++;
        $error("outbound flush longer than one cycle");
    end

    rti_flush_pulse: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        rti_core_flush |=> !rti_core_flush)
    else begin
        fail_cnt++;
        $error("inbound flush longer than one cycle");
    end

endmodule

//--- axi_fifo_bridge_tb.sv
module axi_fifo_bridge_tb
    import axi_fifo_bridge_pkg::*;
();

    localparam int cycle_t        = 8;
    localparam int cycles_per_vec = 300;
    localparam int max_vec        = 64;
    localparam int max_words      = 4;
    localparam int seed           = 99409;

    logic               s_axi_aclk;
    logic               s_axi_aresetn;
    logic [addr_w-1:0]  s_axi_awaddr;
    logic [id_w-1:0]    s_axi_awid;
    logic [len_w-1:0]   s_axi_awlen;
    logic               s_axi_awvalid;
    logic               s_axi_awready;
    logic [data_w-1:0]  s_axi_wdata;
    logic               s_axi_wvalid;
    logic               s_axi_wlast;
    logic               s_axi_wready;
    logic [id_w-1:0]    s_axi_bid;
    logic [resp_w-1:0]  s_axi_bresp;
    logic               s_axi_bvalid;
    logic               s_axi_bready;
    logic [addr_w-1:0]  s_axi_araddr;
    logic [id_w-1:0]    s_axi_arid;
    logic [len_w-1:0]   s_axi_arlen;
    logic               s_axi_arvalid;
    logic               s_axi_arready;
    logic [id_w-1:0]    s_axi_rid;
    logic [data_w-1:0]  s_axi_rdata;
    logic [resp_w-1:0]  s_axi_rresp;
    logic               s_axi_rlast;
    logic               s_axi_rvalid;
    logic               s_axi_rready;
    logic               rto_core_reset;
    logic               rto_core_flush;
    logic               rto_core_write;
    logic [data_w-1:0]  rto_core_fifo_din;
    logic               rto_core_full;
    logic               rti_core_reset;
    logic               rti_core_flush;
    logic               rti_core_rd_en;
    logic [data_w-1:0]  rti_core_fifo_dout;
    logic               rti_core_empty;
    logic [level_w-1:0] data_num;

    // Parsed vector table
    int                 nvec = 0;
    logic               vec_rd    [max_vec];
    logic [addr_w-1:0]  vec_addr  [max_vec];
    logic [id_w-1:0]    vec_id    [max_vec];
    logic [len_w-1:0]   vec_len   [max_vec];
    logic [31:0]        vec_aux   [max_vec];
    int                 vec_nw    [max_vec];
    logic [data_w-1:0]  vec_words [max_vec][max_words];

    // FIFO models and event counts
    logic [data_w-1:0]  out_q[$];
    logic [data_w-1:0]  in_q[$];
    int                 rto_flush_cnt = 0;
    int                 rti_flush_cnt = 0;
    int                 err_value = 0;

    tb_clock_gen u_clock_gen (
        .clk   (s_axi_aclk),
        .rst_n (s_axi_aresetn)
    );

    axi_fifo_bridge axi_fifo_bridge_i (.*);

    bind axi_fifo_bridge axi_fifo_bridge_asserts u_asserts (.*);

    //////////////////////////////////////////////////////////////////////
    // Core models
    //////////////////////////////////////////////////////////////////////

    // First-word-fall-through view of the inbound queue
    task automatic update_inbound_outputs();
        rti_core_empty     = (in_q.size() == 0);
        rti_core_fifo_dout = (in_q.size() > 0) ? in_q[0] : '0;
    endtask

    // Strobes sampled at the edge, outputs moved 1 unit later
    always @(posedge s_axi_aclk) begin
        if (rti_core_rd_en && in_q.size() > 0) begin
            void'(in_q.pop_front());
        end
        if (rto_core_write) begin
            out_q.push_back(rto_core_fifo_din);
        end
        if (rto_core_flush) begin
            rto_flush_cnt++;
        end
        if (rti_core_flush) begin
            rti_flush_cnt++;
        end
        #1;
        update_inbound_outputs();
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic compare(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
                           input string what);
        assert (got === exp) else begin
            err_value++;
            $display("error %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic init_inputs();
        s_axi_awaddr  = '0;
        s_axi_awid    = '0;
        s_axi_awlen   = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_wlast   = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arid    = '0;
        s_axi_arlen   = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        rto_core_full = 1'b0;
        data_num      = '0;
        update_inbound_outputs();
    endtask

    // Columns: op addr id len aux word0..word3
    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        string op;
        fd = $fopen("axi_fifo_bridge_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open axi_fifo_bridge_vectors.txt");
        end else begin
            while (!$feof(fd) && nvec < max_vec) begin
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", op, vec_addr[nvec],
                                vec_id[nvec], vec_len[nvec], vec_aux[nvec],
                                vec_words[nvec][0], vec_words[nvec][1],
                                vec_words[nvec][2], vec_words[nvec][3]);
                    // Comment lines stop parsing before the address column
                    if (n >= 5) begin
                        vec_rd[nvec] = (op == "rd");
                        vec_nw[nvec] = n - 5;
                        nvec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bus transactions
    //////////////////////////////////////////////////////////////////////

    task automatic check_reset();
        repeat (3) @(posedge s_axi_aclk);
        compare(rto_core_reset, 1'b1, "rto_core_reset during reset");
        compare(rti_core_reset, 1'b1, "rti_core_reset during reset");
        compare(s_axi_bvalid, 1'b0, "bvalid during reset");
        compare(s_axi_rvalid, 1'b0, "rvalid during reset");
        wait (s_axi_aresetn);
        repeat (2) @(posedge s_axi_aclk);
        compare(rto_core_reset, 1'b0, "rto_core_reset after reset");
        compare(rti_core_reset, 1'b0, "rti_core_reset after reset");
        compare(s_axi_awready, 1'b1, "awready after reset");
        compare(s_axi_arready, 1'b1, "arready after reset");
        #1;
    endtask

    task automatic write_burst(input int v);
        int                base_out;
        int                base_fo;
        int                base_fi;
        int                exp_fo;
        int                exp_fi;
        int                stall_n;
        int                stall_at;
        logic              is_fifo;
        logic              is_ctrl;
        logic [resp_w-1:0] exp_resp;
        is_fifo  = (vec_addr[v] == addr_fifo);
        is_ctrl  = (vec_addr[v] == addr_ctrl);
        exp_resp = (is_fifo || is_ctrl) ? resp_okay : resp_slverr;
        base_out = out_q.size();
        base_fo  = rto_flush_cnt;
        base_fi  = rti_flush_cnt;
        exp_fo   = 0;
        exp_fi   = 0;
        // Full forced before the second beat, or the only one
        stall_n  = is_fifo ? int'(vec_aux[v]) : 0;
        stall_at = (vec_len[v] > 0) ? 1 : 0;

        s_axi_awaddr  = vec_addr[v];
        s_axi_awid    = vec_id[v];
        s_axi_awlen   = vec_len[v];
        s_axi_awvalid = 1'b1;
        @(posedge s_axi_aclk);
        while (!s_axi_awready) @(posedge s_axi_aclk);
        #1;
        s_axi_awvalid = 1'b0;

        for (int i = 0; i <= int'(vec_len[v]); i++) begin
            // Idle gap first, so no write is in flight when full rises
            if (i == stall_at && stall_n > 0) begin
                s_axi_wvalid = 1'b0;
                @(posedge s_axi_aclk);
                #1;
                rto_core_full = 1'b1;
            end
            s_axi_wdata  = vec_words[v][i];
            s_axi_wlast  = (i == int'(vec_len[v]));
            s_axi_wvalid = 1'b1;
            if (is_ctrl) begin
                exp_fo += vec_words[v][i][0];
                exp_fi += vec_words[v][i][1];
            end
            if (rto_core_full) begin
                repeat (stall_n) begin
                    @(posedge s_axi_aclk);
                    compare(s_axi_wready, 1'b0, $sformatf("vector %0d wready on full", v));
                end
                #1;
                rto_core_full = 1'b0;
            end
            @(posedge s_axi_aclk);
            while (!s_axi_wready) @(posedge s_axi_aclk);
            #1;
        end
        s_axi_wvalid = 1'b0;
        s_axi_wlast  = 1'b0;

        // B with random stalls
        s_axi_bready = ($urandom % 3) != 0;
        @(posedge s_axi_aclk);
        while (!(s_axi_bvalid && s_axi_bready)) begin
            #1;
            s_axi_bready = ($urandom % 3) != 0;
            @(posedge s_axi_aclk);
        end
        compare(s_axi_bid, vec_id[v], $sformatf("vector %0d bid", v));
        compare(s_axi_bresp, exp_resp, $sformatf("vector %0d bresp", v));
        #1;
        s_axi_bready = 1'b0;

        if (is_fifo) begin
            compare(out_q.size() - base_out, int'(vec_len[v]) + 1,
                    $sformatf("vector %0d outbound word count", v));
            for (int i = 0; i <= int'(vec_len[v]) && base_out + i < out_q.size(); i++) begin
                compare(out_q[base_out + i], vec_words[v][i],
                        $sformatf("vector %0d outbound word %0d", v, i));
            end
        end else begin
            compare(out_q.size(), base_out, $sformatf("vector %0d stray writes", v));
        end
        compare(rto_flush_cnt - base_fo, exp_fo, $sformatf("vector %0d rto flushes", v));
        compare(rti_flush_cnt - base_fi, exp_fi, $sformatf("vector %0d rti flushes", v));
    endtask

    task automatic read_burst(input int v);
        int                beats;
        int                exp_beats;
        logic              done;
        logic              has_data;
        logic              is_level;
        logic [resp_w-1:0] exp_resp;
        logic [data_w-1:0] exp_data;
        has_data  = (vec_addr[v] == addr_fifo) && (vec_nw[v] > 0);
        is_level  = (vec_addr[v] == addr_ctrl);
        exp_beats = has_data ? int'(vec_len[v]) + 1 : 1;
        exp_resp  = (has_data || is_level) ? resp_okay : resp_slverr;

        // Preload inbound core and level count
        data_num = vec_aux[v][level_w-1:0];
        if (has_data) begin
            for (int i = 0; i < vec_nw[v]; i++) begin
                in_q.push_back(vec_words[v][i]);
            end
        end
        update_inbound_outputs();

        s_axi_araddr  = vec_addr[v];
        s_axi_arid    = vec_id[v];
        s_axi_arlen   = vec_len[v];
        s_axi_arvalid = 1'b1;
        @(posedge s_axi_aclk);
        while (!s_axi_arready) @(posedge s_axi_aclk);
        #1;
        s_axi_arvalid = 1'b0;

        beats = 0;
        done  = 1'b0;
        while (!done) begin
            s_axi_rready = ($urandom % 3) != 0;
            @(posedge s_axi_aclk);
            if (s_axi_rvalid && s_axi_rready) begin
                compare(s_axi_rid, vec_id[v], $sformatf("vector %0d rid", v));
                compare(s_axi_rresp, exp_resp, $sformatf("vector %0d rresp", v));
                compare(s_axi_rlast, beats == exp_beats - 1,
                        $sformatf("vector %0d rlast beat %0d", v, beats));
                exp_data = has_data ? vec_words[v][beats] : data_w'(data_num);
                if (has_data || is_level) begin
                    compare(s_axi_rdata, exp_data, $sformatf("vector %0d rdata %0d", v, beats));
                end
                beats++;
                done = s_axi_rlast || (beats == exp_beats);
            end
            #1;
        end
        s_axi_rready = 1'b0;
        compare(in_q.size(), 0, $sformatf("vector %0d inbound words left", v));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Run control
    //////////////////////////////////////////////////////////////////////

    initial begin
        wait (nvec > 0);
        #(cycle_t * (nvec * cycles_per_vec + 20));
        $display("timeout: run still busy after %0d cycles", nvec * cycles_per_vec + 20);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        init_inputs();
        void'($urandom(seed));
        load_vectors();
        if (nvec == 0) begin
            $display("no transactions read from axi_fifo_bridge_vectors.txt");
            $display("Simulation failed");
            $finish;
        end else begin
            check_reset();
            for (int v = 0; v < nvec; v++) begin
                if (vec_rd[v]) begin
                    read_burst(v);
                end else begin
                    write_burst(v);
                end
            end
            // Let the bound checks see the last strobes
            repeat (3) @(posedge s_axi_aclk);
            $display("errors: %0d value, %0d assertion", err_value,
                     axi_fifo_bridge_i.u_asserts.fail_cnt);
            if (err_value == 0 && axi_fifo_bridge_i.u_asserts.fail_cnt == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

//--- axi_fifo_bridge_vectors.txt
# op addr id len aux word0..word3, all fields after op in hex
# wr: aux = forced-full cycles, words = W beats; rd: aux = data_num, words = inbound preload
wr 00 00a1 00 0 0123456789abcdef0011223344556677
wr 00 00a2 03 3 deadbeef00000001 deadbeef00000002 deadbeef00000003 deadbeef00000004
wr 00 00a3 01 5 ffffffffffffffffffffffffffffffff 80000000000000000000000000000001
wr 00 00a4 00 2 beef
wr 10 00b1 00 0 1
wr 10 00b2 00 0 2
wr 10 00b3 00 0 3
wr 10 00b4 01 0 1 2
wr 10 00b5 00 0 fffffffffffffffffffffffffffffffc
wr 20 00c1 02 0 aaaa bbbb cccc
wr 3f 00c2 00 0 3
wr 08 00c3 01 0 1 2
wr 00 00a5 02 1 5a5a 6b6b 7c7c
rd 00 0d01 00 0 cafe0000cafe0000cafe0000cafe0001
rd 00 0d02 03 0 1001 1002 1003 1004
rd 10 0d03 00 2a5
rd 10 0d04 00 3ff
rd 00 0d05 00 0
rd 24 0d06 00 0
rd 00 0d07 02 0 a1 a2 a3
rd 10 0d08 00 0
rd 00 0d09 01 0 0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0
wr 00 ffff 03 2 11 22 33 44
rd 3f ffff 00 1

//--- axi_fifo_bridge.f
axi_fifo_bridge_pkg.sv
axi_write_ctrl.sv
axi_read_ctrl.sv
axi_fifo_bridge.sv
tb_clock_gen.sv
axi_fifo_bridge_asserts.sv
axi_fifo_bridge_tb.sv
